/* tb.f */
+incdir+verilog
verilog/vgaDemoPkg.sv
verilog/scanIf.sv
verilog/scanTiming.sv
verilog/approxSquare.sv
verilog/ttLogo.sv
verilog/gradientBg.sv
verilog/pixelOut.sv
verilog/vgaDemoTop.sv
dv/vgaDemoTb.sv

/* run.sh */
#!/bin/sh
# build and run the VGA demo testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module vgaDemoTb -o vgaDemoSim
./obj_dir/vgaDemoSim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

/* dv/vgaDemoTb.sv */
`timescale 1ns/1ps
`include "vgaDemo_config.svh"

module vgaDemoTb;

  localparam int SeedInit = 32'h9832;
  localparam int WaitLimit = `H_TOTAL * `V_TOTAL + 16;   // one frame plus margin
  localparam int NumRows = 8;
  localparam int RandPix = 3;                           // random pixels per gradient row
  localparam int HsStart = `H_ACTIVE + `H_FRONT;
  localparam int HsEnd = HsStart + `H_SYNC;
  localparam int VsStart = `V_ACTIVE + `V_FRONT;
  localparam int VsEnd = VsStart + `V_SYNC;

  logic clk;
  logic rst_n;
  logic [7:0] uiIn;
  logic [7:0] uoOut;

  int ox;            // column of the pixel now on uoOut
  int oy;            // its line
  logic odd;         // its frame parity
  logic locked;
  logic prevHs;
  logic [7:0] shown;
  int frameNum;
  int errors;
  int checks;
  int timeouts;
  integer seed;

  // stimulus table with colour packed as {r,g,b} two bits each
  logic [2:0] rowUi [NumRows];
  logic rowModel [NumRows];     // expected value from the gradient model
  int rowX [NumRows][2];
  int rowY [NumRows][2];
  logic [5:0] rowExp [NumRows];

  vgaDemoTop vgaDemoTop_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .uiIn  (uiIn),
    .uoOut (uoOut)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic logic [1:0] ditherModel(input int c, input int x, input int y,
                                             input logic par);
    logic [2:0] i;
    logic [2:0] k;
    logic [4:0] b;
    i = x[2:0] ^ {3{par}};
    k = i ^ {1'b0, y[1:0]};
    b = {k[0], i[0], k[1], i[1], k[2]};    // interleaved threshold
    return 2'((c + b + (c & 1) + (c >> 5) + (c >> 1)) / 32);
  endfunction

  function automatic logic [5:0] pixelModel(input logic [2:0] ui, input int x, input int y,
                                            input logic par);
    int step;
    int v;
    int r;
    int g;
    int b;
    step = int'(ui[1:0]) + 1;
    v = x - step * y;
    r = ui[2] ? 0 : (v & 63);            // red lane off with bit 2
    g = (-v) & 63;
    b = v & 63;
    return {ditherModel(r, x, y, par), ditherModel(g, x, y, par), ditherModel(b, x, y, par)};
  endfunction

  // TinyVGA byte back to {r,g,b}
  function automatic logic [5:0] colourOf(input logic [7:0] u);
    return {u[0], u[4], u[1], u[5], u[2], u[6]};
  endfunction

  task automatic setRow(input int r, input logic [2:0] ui, input logic model, input int x0,
                        input int y0, input int x1, input int y1, input logic [5:0] e);
    rowUi[r] = ui;
    rowModel[r] = model;
    rowX[r][0] = x0;
    rowY[r][0] = y0;
    rowX[r][1] = x1;
    rowY[r][1] = y1;
    rowExp[r] = e;
  endtask

  task automatic loadTable();
    setRow(0, 3'd0, 1'b0, 700, 100, 300, 500, 6'h00);   // blanking
    setRow(1, 3'd5, 1'b0, 200, 130, 370, 400, 6'h3f);   // bars
    setRow(2, 3'd5, 1'b0, 200, 130, 370, 400, 6'h3f);   // bars in the other parity
    setRow(3, 3'd2, 1'b0, 320, 20, 100, 240, 6'h3f);    // ring top and left
    setRow(4, 3'd6, 1'b0, 540, 240, 320, 460, 6'h3f);   // ring right and bottom
    setRow(5, 3'd0, 1'b1, 40, 10, 180, 240, 6'h00);     // 180,240 inside ring hole
    setRow(6, 3'd3, 1'b1, 110, 170, 600, 300, 6'h00);   // 110,170 ring masked by left cut-out
    setRow(7, 3'd6, 1'b1, 20, 470, 630, 5, 6'h00);
  endtask

  // background only and clear of ring and bars
  task automatic pickBackground(output int x, output int y);
    x = 8 + ($unsigned($random(seed)) % 56);
    if ($random(seed) & 1) begin
      x = x + 569;
    end
    y = $unsigned($random(seed)) % `V_ACTIVE;
  endtask

  // ----------------------------------------------------------------------
  // one clock of output tracking with sync and blanking checks
  // ----------------------------------------------------------------------
  task automatic advance();
    logic hsExp;
    logic vsExp;
    @(negedge clk);
    shown = uoOut;
    if (!locked) begin
      if (prevHs && !shown[7]) begin   // first hsync pulse while still in frame 0
        locked = 1'b1;
        ox = HsStart;
        oy = 0;
        odd = 1'b1;                     // flipped right after reset release
      end
    end else begin
      ox = ox + 1;
      if (ox == `H_TOTAL) begin
        ox = 0;
        oy = (oy + 1 == `V_TOTAL) ? 0 : oy + 1;
      end
      if (ox == 0 && oy == 0) begin
        frameNum++;
      end
      if (ox == 1 && oy == 0) begin
        odd = ~odd;                     // parity lags the origin by a clock
      end
    end
    prevHs = shown[7];
    if (locked) begin
      hsExp = !(ox >= HsStart && ox < HsEnd);
      vsExp = !(oy >= VsStart && oy < VsEnd);
      checks++;
      if (shown[7] !== hsExp) begin
        errors++;
        $display("FAIL hsync at %0d,%0d: got %h expected %h", ox, oy, shown[7], hsExp);
      end
      if (shown[3] !== vsExp) begin
        errors++;
        $display("FAIL vsync at %0d,%0d: got %h expected %h", ox, oy, shown[3], vsExp);
      end
      if ((ox >= `H_ACTIVE || oy >= `V_ACTIVE) && colourOf(shown) !== 6'h00) begin
        errors++;
        $display("FAIL uoOut blank at %0d,%0d: got %h expected 00", ox, oy, colourOf(shown));
      end
    end
  endtask

  task automatic waitFrame();
    int n;
    int f0;
    advance();                          // a start on this clock saw the old control
    f0 = frameNum;
    n = 0;
    while (frameNum == f0 && n < WaitLimit) begin
      advance();
      n++;
    end
    if (frameNum == f0) begin
      timeouts++;
      $display("ERROR: no frame start seen within %0d clocks", WaitLimit);
    end
  endtask

  task automatic waitPixel(input int x, input int y);
    int n;
    n = 0;
    do begin
      advance();
      n++;
    end while (!(ox == x && oy == y) && n < WaitLimit);
    if (!(ox == x && oy == y)) begin
      timeouts++;
      $display("ERROR: pixel %0d,%0d never appeared on the output", x, y);
    end
  endtask

  task automatic checkReset(input string when);
    checks++;
    if (uoOut !== 8'h88) begin
      errors++;
      $display("FAIL uoOut %s: got %h expected 88", when, uoOut);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int k;
    int r;
    int p;
    int n;
    int x;
    int y;
    logic [5:0] expC;
    clk = 1'b0;
    rst_n = 1'b0;
    uiIn = 8'h00;
    locked = 1'b0;
    prevHs = 1'b1;
    odd = 1'b0;
    ox = 0;
    oy = 0;
    frameNum = 0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    seed = SeedInit;
    loadTable();

    for (k = 0; k < 4; k++) begin
      @(posedge clk);
      #1;
      checkReset("during reset");
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    checkReset("one cycle after reset");   // origin pixel is black

    n = 0;
    while (!locked && n < 2 * `H_TOTAL) begin
      advance();
      n++;
    end
    if (!locked) begin
      timeouts++;
      $display("ERROR: hsync never went low after reset");
    end

    for (r = 0; r < NumRows && timeouts == 0; r++) begin
      @(posedge clk);
      #1 uiIn = {5'b0, rowUi[r]};
      waitFrame();
      for (p = 0; p < 2 + (rowModel[r] ? RandPix : 0) && timeouts == 0; p++) begin
        if (p < 2) begin
          x = rowX[r][p];
          y = rowY[r][p];
        end else begin
          pickBackground(x, y);
        end
        waitPixel(x, y);
        if (timeouts == 0) begin
          expC = rowModel[r] ? pixelModel(rowUi[r], x, y, odd) : rowExp[r];
          checks++;
          if (colourOf(shown) !== expC) begin
            errors++;
            $display("FAIL uoOut colour row %0d at %0d,%0d: got %h expected %h",
                     r, x, y, colourOf(shown), expC);
          end
        end
      end
    end

    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/vgaDemoTop.sv */
`timescale 1ns/1ps

module vgaDemoTop (
  input  logic clk,
  input  logic rst_n,
  input  logic [7:0] uiIn,    // bits 2..0 steer the gradient
  output logic [7:0] uoOut    // TinyVGA pinout
);

  logic logo;
  vgaDemoPkg::rgb18_u bgColor;

  // raster position and syncs shared by all stages
  scanIf scanBus ();

  scanTiming scanTiming_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .scan  (scanBus.source)
  );

  // ----------------------------------------------------------------------
  // pixel sources, both zero latency on the scan
  // ----------------------------------------------------------------------
  ttLogo ttLogo_inst (
    .scan (scanBus.sink),
    .logo (logo)
  );

  gradientBg gradientBg_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .scan    (scanBus.sink),
    .uiIn    (uiIn[2:0]),
    .bgColor (bgColor)
  );

  // compositor and output register
  pixelOut pixelOut_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .scan    (scanBus.sink),
    .logo    (logo),
    .bgColor (bgColor),
    .uoOut   (uoOut)
  );

endmodule

/* verilog/pixelOut.sv */
`timescale 1ns/1ps
`include "vgaDemo_config.svh"

module pixelOut (
  input  logic clk,
  input  logic rst_n,
  scanIf.sink  scan,
  input  logic logo,
  input  vgaDemoPkg::rgb18_u bgColor,
  output logic [7:0] uoOut
);

  localparam vgaDemoPkg::colorChan_t logoLevel = `LOGO_LEVEL;

  vgaDemoPkg::rgb18_u pixColor;
  logic [2:0] bayerI;
  logic [1:0] bayerJ;
  logic [2:0] bayerX;
  logic [4:0] bayer;
  logic [1:0] redQ, greenQ, blueQ;
  logic [7:0] uoNext;

  // 6-bit channel plus threshold, top two bits of the sum
  function automatic logic [1:0] dither2(input vgaDemoPkg::colorChan_t c,
                                         input logic [4:0] b);
    logic [`COLOR_W:0] sum;
    sum = (`COLOR_W + 1)'(c) + (`COLOR_W + 1)'(b)
        + (`COLOR_W + 1)'(c[0]) + (`COLOR_W + 1)'(c[`COLOR_W-1])
        + (`COLOR_W + 1)'(c[`COLOR_W-1:1]);    // stretch so 63 saturates to 3
    return sum[`COLOR_W -: 2];
  endfunction

  // logo overrides the gradient
  assign pixColor.word = logo ? {3{logoLevel}} : bgColor.word;

  // ----------------------------------------------------------------------
  // 8x4 Bayer, x index mirrored on odd frames
  // ----------------------------------------------------------------------
  assign bayerI = scan.hPos[2:0] ^ {3{scan.frameOdd}};
  assign bayerJ = scan.vPos[1:0];
  assign bayerX = {bayerI[2], bayerI[1] ^ bayerJ[1], bayerI[0] ^ bayerJ[0]};
  assign bayer = {bayerX[0], bayerI[0], bayerX[1], bayerI[1], bayerX[2]};  // bit-interleave

  // blank outside the visible window
  assign redQ = scan.displayOn ? dither2(pixColor.ch.red, bayer) : 2'b00;
  assign greenQ = scan.displayOn ? dither2(pixColor.ch.green, bayer) : 2'b00;
  assign blueQ = scan.displayOn ? dither2(pixColor.ch.blue, bayer) : 2'b00;

  // TinyVGA pin order
  assign uoNext = {scan.hSync, blueQ[0], greenQ[0], redQ[0],
                   scan.vSync, blueQ[1], greenQ[1], redQ[1]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uoOut <= 8'b1000_1000;          // syncs idle high, black
    end else begin
      uoOut <= uoNext;                // one clock behind the scan
    end
  end

endmodule

/* verilog/gradientBg.sv */
`timescale 1ns/1ps
`include "vgaDemo_config.svh"

module gradientBg (
  input  logic clk,
  input  logic rst_n,
  scanIf.sink  scan,
  input  logic [2:0] uiIn,
  output vgaDemoPkg::rgb18_u bgColor
);

  localparam int LaneW = `COLOR_W;
  localparam int WordW = 3 * `COLOR_W;
  localparam vgaDemoPkg::coord_t hLast = `H_TOTAL - 1;
  localparam vgaDemoPkg::coord_t vLast = `V_TOTAL - 1;

  logic [2:0] ctrl;             // control held for the whole frame
  logic [WordW-1:0] rowAcc;     // value at x = 0 of the current line
  logic [WordW-1:0] pixAcc;     // value of the pixel now on the bus
  logic [WordW-1:0] incNow;
  logic [WordW-1:0] incFrame;
  logic [WordW-1:0] rowStep;
  logic lineEnd;
  logic frameEnd;

  // three independent 6-bit adds, no carry between lanes
  function automatic logic [WordW-1:0] laneAdd(input logic [WordW-1:0] a,
                                               input logic [WordW-1:0] b);
    logic [WordW-1:0] s;
    for (int k = 0; k < 3; k++) begin
      s[k*LaneW +: LaneW] = a[k*LaneW +: LaneW] + b[k*LaneW +: LaneW];
    end
    return s;
  endfunction

  // per lane  -(inc * step)  mod 64
  function automatic logic [WordW-1:0] laneNegScale(input logic [WordW-1:0] inc,
                                                    input logic [1:0] sel);
    logic [WordW-1:0] s;
    logic [LaneW-1:0] p;
    for (int k = 0; k < 3; k++) begin
      p = inc[k*LaneW +: LaneW] * (LaneW'(sel) + 1'b1);  // step is sel + 1
      s[k*LaneW +: LaneW] = -p;
    end
    return s;
  endfunction

  // red +1 unless bit 2 set, green -1, blue +1
  function automatic logic [WordW-1:0] incFor(input logic [2:0] c);
    return {{(LaneW-1){1'b0}}, ~c[2], {LaneW{1'b1}}, {(LaneW-1){1'b0}}, 1'b1};
  endfunction

  assign incNow = incFor(uiIn);       // first step of a new frame
  assign incFrame = incFor(ctrl);
  assign rowStep = laneNegScale(incFrame, ctrl[1:0]);

  assign lineEnd = (scan.hPos == hLast);
  assign frameEnd = lineEnd && (scan.vPos == vLast);

  // ----------------------------------------------------------------------
  // accumulators, one step ahead of the scan
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl <= '0;
      rowAcc <= '0;
      pixAcc <= '0;
    end else if (scan.frameStart) begin
      ctrl <= uiIn;                   // sample control once per frame
      rowAcc <= '0;
      pixAcc <= incNow;               // pixel 1,0
    end else if (frameEnd) begin
      pixAcc <= '0;                   // origin is always zero
    end else if (lineEnd) begin
      rowAcc <= laneAdd(rowAcc, rowStep);
      pixAcc <= laneAdd(rowAcc, rowStep);  // x = 0 of next line
    end else begin
      pixAcc <= laneAdd(pixAcc, incFrame);
    end
  end

  assign bgColor.word = pixAcc;

endmodule

/* verilog/ttLogo.sv */
`timescale 1ns/1ps
`include "vgaDemo_config.svh"

module ttLogo (
  scanIf.sink scan,
  output logic logo
);

  localparam int ringOuterSq = `RING_OUTER * `RING_OUTER;
  localparam int ringInnerSq = (`RING_OUTER - `RING_WIDTH) * (`RING_OUTER - `RING_WIDTH);
  localparam int xo = `LOGO_X_OFF;

  logic signed [10:0] dx;
  logic signed [10:0] dy;
  logic nearX;
  logic nearY;
  logic [17:0] xSq;
  logic [17:0] ySq;
  logic [18:0] rSq;
  logic ring;
  logic hat0, leg0, hat1, leg1;
  logic cut0, cut1;

  // x0,y0 corner, w by h box
  function automatic logic inRect(input vgaDemoPkg::coord_t x, input vgaDemoPkg::coord_t y,
                                  input int x0, input int w, input int y0, input int h);
    return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
  endfunction

  // ----------------------------------------------------------------------
  // ring, offsets from centre squared approximately
  // ----------------------------------------------------------------------
  assign dx = $signed({1'b0, scan.hPos}) - 11'sd`RING_CX;
  assign dy = $signed({1'b0, scan.vPos}) - 11'sd`RING_CY;

  // 9-bit squarers alias beyond +-256, far outside the ring anyway
  assign nearX = (dx[10:8] == 3'b000) || (dx[10:8] == 3'b111);
  assign nearY = (dy[10:8] == 3'b000) || (dy[10:8] == 3'b111);

  approxSquare #(.W(9), .T(4), .R(4)) sqX (.a(dx[8:0]), .pApprox(xSq));
  approxSquare #(.W(9), .T(4), .R(3)) sqY (.a(dy[8:0]), .pApprox(ySq));

  assign rSq = {1'b0, xSq} + {1'b0, ySq};
  assign ring = nearX && nearY && (rSq < ringOuterSq) && (rSq > ringInnerSq);

  // ----------------------------------------------------------------------
  // bars and cut-outs
  // ----------------------------------------------------------------------
  assign hat0 = inRect(scan.hPos, scan.vPos, xo + 46, 240, 100, 64);   // upper hat
  assign leg0 = inRect(scan.hPos, scan.vPos, xo + 144, 70, 100, 228);  // left stem
  assign hat1 = inRect(scan.hPos, scan.vPos, xo + 144, 254, 222, 64);  // lower hat
  assign leg1 = inRect(scan.hPos, scan.vPos, xo + 256, 70, 222, 240);  // right stem

  // gaps in the ring next to the bars
  assign cut0 = inRect(scan.hPos, scan.vPos, xo, 144, 164, 18);
  assign cut1 = inRect(scan.hPos, scan.vPos, xo + 326, 22, 286, 194);

  assign logo = (ring && !cut0 && !cut1) || hat0 || leg0 || hat1 || leg1;

endmodule

/* verilog/approxSquare.sv */
`timescale 1ns/1ps

module approxSquare #(
  parameter int W = 12,   // input width
  parameter int T = 4,    // low bits dropped from the main square
  parameter int R = 3     // top low bits kept for the cross term
) (
  input  logic signed [W-1:0] a,
  output logic [2*W-1:0] pApprox
);

  localparam int H = W - T;   // high part width

  logic [W-1:0] mag;
  logic [H-1:0] hiPart;
  logic [R-1:0] loTop;
  logic [2*H-1:0] hiSq;
  logic [H+R-1:0] crossProd;

  // square only needs the magnitude
  assign mag = a[W-1] ? $unsigned(-a) : $unsigned(a);

  assign hiPart = mag[W-1:T];
  assign loTop = mag[T-1 -: R];     // top R bits of the low part

  assign hiSq = hiPart * hiPart;    // 2H-bit product
  assign crossProd = hiPart * loTop;  // small H x R product

  // hi^2 << 2T  plus  2*hi*lo << T, with lo ~ loTop << (T-R)
  assign pApprox = ((2*W)'(hiSq) << (2*T))
                 + ((2*W)'(crossProd) << (2*T - R + 1));

endmodule

/* verilog/scanTiming.sv */
`timescale 1ns/1ps
`include "vgaDemo_config.svh"

module scanTiming (
  input logic clk,
  input logic rst_n,
  scanIf.source scan
);

  localparam vgaDemoPkg::coord_t hLast = `H_TOTAL - 1;
  localparam vgaDemoPkg::coord_t vLast = `V_TOTAL - 1;
  localparam int hSyncStart = `H_ACTIVE + `H_FRONT;   // pulse starts after front porch
  localparam int hSyncEnd = `H_TOTAL - `H_BACK;       // and ends where back porch begins
  localparam int vSyncStart = `V_ACTIVE + `V_FRONT;
  localparam int vSyncEnd = `V_TOTAL - `V_BACK;

  vgaDemoPkg::coord_t hCnt;
  vgaDemoPkg::coord_t vCnt;
  logic oddFrame;
  logic atOrigin;

  // ----------------------------------------------------------------------
  // pixel and line counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hCnt <= '0;
      vCnt <= '0;
      oddFrame <= 1'b0;
    end else begin
      if (hCnt == hLast) begin
        hCnt <= '0;
        if (vCnt == vLast) begin
          vCnt <= '0;                 // wrap to top of next frame
        end else begin
          vCnt <= vCnt + 1'b1;
        end
      end else begin
        hCnt <= hCnt + 1'b1;
      end
      if (atOrigin) begin
        oddFrame <= ~oddFrame;        // flips one clock after the strobe
      end
    end
  end

  assign atOrigin = (hCnt == '0) && (vCnt == '0);

  // decodes straight off the counters, no extra stage
  assign scan.hPos = hCnt;
  assign scan.vPos = vCnt;
  assign scan.hSync = ~((hCnt >= hSyncStart) && (hCnt < hSyncEnd));  // negative pulse
  assign scan.vSync = ~((vCnt >= vSyncStart) && (vCnt < vSyncEnd));
  assign scan.displayOn = (hCnt < `H_ACTIVE) && (vCnt < `V_ACTIVE);
  assign scan.frameStart = atOrigin;
  assign scan.frameOdd = oddFrame;

endmodule

/* verilog/scanIf.sv */
`timescale 1ns/1ps

interface scanIf;
  vgaDemoPkg::coord_t hPos;   // current pixel column
  vgaDemoPkg::coord_t vPos;   // current line
  logic displayOn;            // inside the 640x480 window
  logic hSync;                // active low, decoded from hPos
  logic vSync;                // active low, decoded from vPos
  logic frameStart;           // high for the single clock at 0,0
  logic frameOdd;             // frame parity for the dither toggle

  modport source (
    output hPos, vPos, displayOn, hSync, vSync, frameStart, frameOdd
  );

  modport sink (
    input hPos, vPos, displayOn, hSync, vSync, frameStart, frameOdd
  );
endinterface

/* verilog/vgaDemoPkg.sv */
package vgaDemoPkg;

  // one colour channel before dithering
  typedef logic [5:0] colorChan_t;

  // per-channel view, red in the top bits
  typedef struct packed {
    colorChan_t red;
    colorChan_t green;
    colorChan_t blue;
  } rgbChans_t;

  // same 18-bit colour word, whole or split into lanes
  typedef union packed {
    logic [17:0] word;  // lane-wise arithmetic on the whole word
    rgbChans_t   ch;    // channel access for the dither stage
  } rgb18_u;

  // raster coordinate, covers 0..799 and 0..524
  typedef logic [9:0] coord_t;

endpackage

/* verilog/vgaDemo_config.svh */
`ifndef VGADEMO_CONFIG_SVH
`define VGADEMO_CONFIG_SVH

// ----------------------------------------------------------------------
// 640x480 raster timing, in pixel clocks and lines
// ----------------------------------------------------------------------
`define H_ACTIVE 640        // visible pixels per line
`define H_FRONT 16          // front porch
`define H_SYNC 96           // hsync pulse width
`define H_BACK 48           // back porch
`define H_TOTAL 800         // clocks per line

`define V_ACTIVE 480        // visible lines
`define V_FRONT 10
`define V_SYNC 2            // vsync pulse, in lines
`define V_BACK 33
`define V_TOTAL 525         // lines per frame

// ----------------------------------------------------------------------
// logo placement and ring
// ----------------------------------------------------------------------
`define LOGO_X_OFF 80       // left edge of the bar artwork
`define RING_OUTER 238      // outer radius
`define RING_WIDTH 36       // inner radius is outer minus this
`define RING_CX 320         // ring centre
`define RING_CY 240

// colour depth before dithering
`define COLOR_W 6
`define LOGO_LEVEL 63       // full white per channel

`endif
